/* design/ama_riscv_defines.svh */
`ifndef AMA_RISCV_DEFINES_SVH
`define AMA_RISCV_DEFINES_SVH

// Hardwired zero register index
`define RF_X0_ZERO 5'd0

// addi x0, x0, 0
`define NOP_INST 32'h0000_0013

`endif

/* design/ama_riscv_isa_pkg.sv */
package ama_riscv_isa_pkg;

typedef logic [31:0] word_t;
typedef logic [31:0] inst_t;
typedef logic [4:0]  reg_idx_t;

// Major opcodes of the supported subset
localparam logic [6:0] OPC_OP     = 7'b011_0011;
localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
localparam logic [6:0] OPC_LUI    = 7'b011_0111;
localparam logic [6:0] OPC_AUIPC  = 7'b001_0111;
localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
localparam logic [6:0] OPC_STORE  = 7'b010_0011;

// funct3 for OP and OP-IMM
localparam logic [2:0] F3_ADD_SUB = 3'b000;
localparam logic [2:0] F3_SLL     = 3'b001;
localparam logic [2:0] F3_SLT     = 3'b010;
localparam logic [2:0] F3_SLTU    = 3'b011;
localparam logic [2:0] F3_XOR     = 3'b100;
localparam logic [2:0] F3_SRL_SRA = 3'b101;
localparam logic [2:0] F3_OR      = 3'b110;
localparam logic [2:0] F3_AND     = 3'b111;

// Word store only
localparam logic [2:0] F3_SW = 3'b010;

localparam logic [6:0] F7_BASE = 7'b000_0000;
localparam logic [6:0] F7_ALT  = 7'b010_0000;

typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
} alu_op_t;

// Encoded as the branch funct3 so decode is a cast
typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
} branch_op_t;

endpackage

/* design/ama_riscv_pipe_pkg.sv */
package ama_riscv_pipe_pkg;

typedef enum logic [1:0] {
    ALU_A_SEL_RS1     = 2'd0,
    ALU_A_SEL_PC      = 2'd1,
    ALU_A_SEL_FWD_ALU = 2'd2
} alu_a_sel_t;

typedef enum logic [1:0] {
    ALU_B_SEL_RS2     = 2'd0,
    ALU_B_SEL_IMM     = 2'd1,
    ALU_B_SEL_FWD_ALU = 2'd2
} alu_b_sel_t;

// Decoded control of one instruction
typedef struct packed {
    ama_riscv_isa_pkg::reg_idx_t   rs1;
    ama_riscv_isa_pkg::reg_idx_t   rs2;
    ama_riscv_isa_pkg::reg_idx_t   rd;
    logic                          rd_we;
    logic                          store_inst;
    logic                          branch_inst;
    ama_riscv_isa_pkg::branch_op_t branch_op;
    ama_riscv_isa_pkg::alu_op_t    alu_op;
    alu_a_sel_t                    alu_a_sel;
    alu_b_sel_t                    alu_b_sel;
} ctrl_t;

// Valid writer of a nonzero rd in EXE and MEM
typedef struct packed {
    logic exe;
    logic mem;
} rd_we_t;

typedef struct packed {
    alu_a_sel_t alu_a_sel;
    alu_b_sel_t alu_b_sel;
    logic       bc_a_sel;
    logic       bcs_b_sel;
    logic       rf_a_sel;
    logic       rf_b_sel;
} fwd_sel_t;

// DEC/EXE register
typedef struct packed {
    logic                     valid;
    ctrl_t                    ctrl;
    ama_riscv_isa_pkg::word_t pc;
    ama_riscv_isa_pkg::word_t imm;
    ama_riscv_isa_pkg::word_t rs1_data;
    ama_riscv_isa_pkg::word_t rs2_data;
    fwd_sel_t                 fwd_sel;
} exe_stage_t;

// EXE/MEM register
typedef struct packed {
    logic                        valid;
    logic                        rd_we;
    ama_riscv_isa_pkg::reg_idx_t rd;
    ama_riscv_isa_pkg::word_t    alu_result;
} mem_stage_t;

typedef struct packed {
    logic                        we;
    ama_riscv_isa_pkg::reg_idx_t rd;
    ama_riscv_isa_pkg::word_t    data;
} wb_t;

typedef struct packed {
    logic                     we;
    ama_riscv_isa_pkg::word_t addr;
    ama_riscv_isa_pkg::word_t data;
} dmem_wr_t;

endpackage

/* design/ama_riscv_decoder.sv */
`timescale 1ns/1ps
`include "ama_riscv_defines.svh"

module ama_riscv_decoder (
    input  ama_riscv_isa_pkg::inst_t  inst,
    output ama_riscv_pipe_pkg::ctrl_t ctrl,
    output ama_riscv_isa_pkg::word_t  imm
);

logic [6:0] opcode;
logic [2:0] funct3;
logic [6:0] funct7;
ama_riscv_isa_pkg::reg_idx_t rs1;
ama_riscv_isa_pkg::reg_idx_t rs2;
ama_riscv_isa_pkg::reg_idx_t rd;
logic rd_nz;
logic r_type;
logic f7_base;
logic f7_alt;
logic arith_ok;
logic branch_ok;
ama_riscv_isa_pkg::alu_op_t arith_op;
ama_riscv_isa_pkg::word_t imm_i;
ama_riscv_isa_pkg::word_t imm_s;
ama_riscv_isa_pkg::word_t imm_b;
ama_riscv_isa_pkg::word_t imm_u;

assign opcode = inst[6:0];
assign rd     = inst[11:7];
assign funct3 = inst[14:12];
assign rs1    = inst[19:15];
assign rs2    = inst[24:20];
assign funct7 = inst[31:25];

assign rd_nz   = (rd != `RF_X0_ZERO);
assign r_type  = (opcode == ama_riscv_isa_pkg::OPC_OP);
assign f7_base = (funct7 == ama_riscv_isa_pkg::F7_BASE);
assign f7_alt  = (funct7 == ama_riscv_isa_pkg::F7_ALT);

assign imm_i = {{20{inst[31]}}, inst[31:20]};
assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
assign imm_u = {inst[31:12], 12'd0};

assign branch_ok = funct3 inside {
    ama_riscv_isa_pkg::BR_BEQ, ama_riscv_isa_pkg::BR_BNE,
    ama_riscv_isa_pkg::BR_BLT, ama_riscv_isa_pkg::BR_BGE,
    ama_riscv_isa_pkg::BR_BLTU, ama_riscv_isa_pkg::BR_BGEU
};

// ALU op shared by register and immediate forms
always_comb begin
    arith_op = ama_riscv_isa_pkg::ALU_ADD;
    arith_ok = !r_type || f7_base;
    case (funct3)
        ama_riscv_isa_pkg::F3_ADD_SUB: begin
            arith_op = (r_type && f7_alt) ? ama_riscv_isa_pkg::ALU_SUB
                                          : ama_riscv_isa_pkg::ALU_ADD;
            arith_ok = !r_type || f7_base || f7_alt;
        end
        ama_riscv_isa_pkg::F3_SLL: begin
            arith_op = ama_riscv_isa_pkg::ALU_SLL;
            arith_ok = f7_base;
        end
        ama_riscv_isa_pkg::F3_SLT:  arith_op = ama_riscv_isa_pkg::ALU_SLT;
        ama_riscv_isa_pkg::F3_SLTU: arith_op = ama_riscv_isa_pkg::ALU_SLTU;
        ama_riscv_isa_pkg::F3_XOR:  arith_op = ama_riscv_isa_pkg::ALU_XOR;
        ama_riscv_isa_pkg::F3_SRL_SRA: begin
            // Shift immediates carry funct7 too
            arith_op = f7_alt ? ama_riscv_isa_pkg::ALU_SRA : ama_riscv_isa_pkg::ALU_SRL;
            arith_ok = f7_base || f7_alt;
        end
        ama_riscv_isa_pkg::F3_OR:   arith_op = ama_riscv_isa_pkg::ALU_OR;
        default:                    arith_op = ama_riscv_isa_pkg::ALU_AND;
    endcase
end

always_comb begin
    // Defaults decode as addi x0, x0, 0
    ctrl.rs1         = `RF_X0_ZERO;
    ctrl.rs2         = `RF_X0_ZERO;
    ctrl.rd          = `RF_X0_ZERO;
    ctrl.rd_we       = 1'b0;
    ctrl.store_inst  = 1'b0;
    ctrl.branch_inst = 1'b0;
    ctrl.branch_op   = ama_riscv_isa_pkg::BR_BEQ;
    ctrl.alu_op      = ama_riscv_isa_pkg::ALU_ADD;
    ctrl.alu_a_sel   = ama_riscv_pipe_pkg::ALU_A_SEL_RS1;
    ctrl.alu_b_sel   = ama_riscv_pipe_pkg::ALU_B_SEL_IMM;
    imm              = '0;
    case (opcode)
        ama_riscv_isa_pkg::OPC_OP: begin
            if (arith_ok) begin
                ctrl.rs1       = rs1;
                ctrl.rs2       = rs2;
                ctrl.rd        = rd;
                ctrl.rd_we     = rd_nz;
                ctrl.alu_op    = arith_op;
                ctrl.alu_b_sel = ama_riscv_pipe_pkg::ALU_B_SEL_RS2;
            end
        end
        ama_riscv_isa_pkg::OPC_OP_IMM: begin
            if (arith_ok) begin
                ctrl.rs1    = rs1;
                ctrl.rd     = rd;
                ctrl.rd_we  = rd_nz;
                ctrl.alu_op = arith_op;
                imm         = imm_i;
            end
        end
        ama_riscv_isa_pkg::OPC_LUI: begin
            ctrl.rd     = rd;
            ctrl.rd_we  = rd_nz;
            ctrl.alu_op = ama_riscv_isa_pkg::ALU_PASS_B;
            imm         = imm_u;
        end
        ama_riscv_isa_pkg::OPC_AUIPC: begin
            ctrl.rd        = rd;
            ctrl.rd_we     = rd_nz;
            ctrl.alu_a_sel = ama_riscv_pipe_pkg::ALU_A_SEL_PC;
            imm            = imm_u;
        end
        ama_riscv_isa_pkg::OPC_BRANCH: begin
            // ALU forms the target as pc + imm
            if (branch_ok) begin
                ctrl.rs1         = rs1;
                ctrl.rs2         = rs2;
                ctrl.branch_inst = 1'b1;
                ctrl.branch_op   = ama_riscv_isa_pkg::branch_op_t'(funct3);
                ctrl.alu_a_sel   = ama_riscv_pipe_pkg::ALU_A_SEL_PC;
                imm              = imm_b;
            end
        end
        ama_riscv_isa_pkg::OPC_STORE: begin
            if (funct3 == ama_riscv_isa_pkg::F3_SW) begin
                ctrl.rs1        = rs1;
                ctrl.rs2        = rs2;
                ctrl.store_inst = 1'b1;
                imm             = imm_s;
            end
        end
        default: begin
            imm = '0;
        end
    endcase
end

endmodule

/* design/ama_riscv_reg_file.sv */
`timescale 1ns/1ps
`include "ama_riscv_defines.svh"

module ama_riscv_reg_file (
    input  logic                        clk,
    input  ama_riscv_isa_pkg::reg_idx_t rs1,
    input  ama_riscv_isa_pkg::reg_idx_t rs2,
    output ama_riscv_isa_pkg::word_t    rs1_data,
    output ama_riscv_isa_pkg::word_t    rs2_data,
    input  logic                        we,
    input  ama_riscv_isa_pkg::reg_idx_t rd,
    input  ama_riscv_isa_pkg::word_t    rd_data
);

// x1..x31, x0 has no storage
ama_riscv_isa_pkg::word_t regs [1:31];

always_ff @(posedge clk) begin
    if (we && (rd != `RF_X0_ZERO)) begin
        regs[rd] <= rd_data;
    end
end

// Same-cycle write is not visible here, the core bypasses it
assign rs1_data = (rs1 == `RF_X0_ZERO) ? '0 : regs[rs1];
assign rs2_data = (rs2 == `RF_X0_ZERO) ? '0 : regs[rs2];

endmodule

/* design/ama_riscv_operand_forwarding.sv */
`timescale 1ns/1ps
`include "ama_riscv_defines.svh"

module ama_riscv_operand_forwarding (
    input  ama_riscv_pipe_pkg::rd_we_t     rd_we,
    input  logic                           store_inst_dec,
    input  logic                           branch_inst_dec,
    input  ama_riscv_isa_pkg::reg_idx_t    rs1_dec,
    input  ama_riscv_isa_pkg::reg_idx_t    rs2_dec,
    input  ama_riscv_isa_pkg::reg_idx_t    rd_exe,
    input  ama_riscv_isa_pkg::reg_idx_t    rd_mem,
    input  ama_riscv_pipe_pkg::alu_a_sel_t alu_a_sel_dec,
    input  ama_riscv_pipe_pkg::alu_b_sel_t alu_b_sel_dec,
    output ama_riscv_pipe_pkg::fwd_sel_t   fwd_sel
);

logic rs1_nz;
logic rs2_nz;
logic a_hit_exe;
logic b_hit_exe;
logic a_hit_mem;
logic b_hit_mem;
logic a_uses_rs1;
logic b_uses_rs2;

assign rs1_nz = (rs1_dec != `RF_X0_ZERO);
assign rs2_nz = (rs2_dec != `RF_X0_ZERO);

// Producer one ahead sits in EXE, two ahead in MEM/WB
assign a_hit_exe = rs1_nz && (rs1_dec == rd_exe) && rd_we.exe;
assign b_hit_exe = rs2_nz && (rs2_dec == rd_exe) && rd_we.exe;
assign a_hit_mem = rs1_nz && (rs1_dec == rd_mem) && rd_we.mem;
assign b_hit_mem = rs2_nz && (rs2_dec == rd_mem) && rd_we.mem;

assign a_uses_rs1 = (alu_a_sel_dec == ama_riscv_pipe_pkg::ALU_A_SEL_RS1);
assign b_uses_rs2 = (alu_b_sel_dec == ama_riscv_pipe_pkg::ALU_B_SEL_RS2);

// ALU operand A
always_comb begin
    if (a_hit_exe && a_uses_rs1) begin
        fwd_sel.alu_a_sel = ama_riscv_pipe_pkg::ALU_A_SEL_FWD_ALU;
    end else begin
        fwd_sel.alu_a_sel = alu_a_sel_dec;
    end
end

// ALU operand B
always_comb begin
    if (b_hit_exe && b_uses_rs2) begin
        fwd_sel.alu_b_sel = ama_riscv_pipe_pkg::ALU_B_SEL_FWD_ALU;
    end else begin
        fwd_sel.alu_b_sel = alu_b_sel_dec;
    end
end

// Branch compare A
assign fwd_sel.bc_a_sel = a_hit_exe && branch_inst_dec;

// Branch compare B, also the store data
assign fwd_sel.bcs_b_sel = b_hit_exe && (store_inst_dec || branch_inst_dec);

// Write-back bypass of the register file reads
assign fwd_sel.rf_a_sel = a_hit_mem && (a_uses_rs1 || branch_inst_dec);
assign fwd_sel.rf_b_sel = b_hit_mem && (b_uses_rs2 || branch_inst_dec || store_inst_dec);

endmodule

/* design/ama_riscv_execute.sv */
`timescale 1ns/1ps

module ama_riscv_execute (
    input  ama_riscv_pipe_pkg::exe_stage_t exe,
    input  ama_riscv_isa_pkg::word_t       alu_fwd_data,
    output ama_riscv_isa_pkg::word_t       alu_result,
    output logic                           branch_taken,
    output ama_riscv_isa_pkg::word_t       branch_target,
    output ama_riscv_pipe_pkg::dmem_wr_t   dmem_wr
);

ama_riscv_isa_pkg::word_t op_a;
ama_riscv_isa_pkg::word_t op_b;
ama_riscv_isa_pkg::word_t alu_out;
ama_riscv_isa_pkg::word_t cmp_a;
ama_riscv_isa_pkg::word_t cmp_b;
logic [4:0] shamt;
logic cmp_true;

// Operand A
always_comb begin
    case (exe.fwd_sel.alu_a_sel)
        ama_riscv_pipe_pkg::ALU_A_SEL_PC:      op_a = exe.pc;
        ama_riscv_pipe_pkg::ALU_A_SEL_FWD_ALU: op_a = alu_fwd_data;
        default:                               op_a = exe.rs1_data;
    endcase
end

// Operand B
always_comb begin
    case (exe.fwd_sel.alu_b_sel)
        ama_riscv_pipe_pkg::ALU_B_SEL_IMM:     op_b = exe.imm;
        ama_riscv_pipe_pkg::ALU_B_SEL_FWD_ALU: op_b = alu_fwd_data;
        default:                               op_b = exe.rs2_data;
    endcase
end

assign shamt = op_b[4:0];

always_comb begin
    case (exe.ctrl.alu_op)
        ama_riscv_isa_pkg::ALU_SUB:    alu_out = op_a - op_b;
        ama_riscv_isa_pkg::ALU_SLL:    alu_out = op_a << shamt;
        ama_riscv_isa_pkg::ALU_SLT:    alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
        ama_riscv_isa_pkg::ALU_SLTU:   alu_out = {31'd0, op_a < op_b};
        ama_riscv_isa_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
        ama_riscv_isa_pkg::ALU_SRL:    alu_out = op_a >> shamt;
        ama_riscv_isa_pkg::ALU_SRA:    alu_out = $signed(op_a) >>> shamt;
        ama_riscv_isa_pkg::ALU_OR:     alu_out = op_a | op_b;
        ama_riscv_isa_pkg::ALU_AND:    alu_out = op_a & op_b;
        // LUI
        ama_riscv_isa_pkg::ALU_PASS_B: alu_out = op_b;
        default:                       alu_out = op_a + op_b;
    endcase
end

// Compare operands, B is also the store data
assign cmp_a = exe.fwd_sel.bc_a_sel ? alu_fwd_data : exe.rs1_data;
assign cmp_b = exe.fwd_sel.bcs_b_sel ? alu_fwd_data : exe.rs2_data;

always_comb begin
    case (exe.ctrl.branch_op)
        ama_riscv_isa_pkg::BR_BNE:  cmp_true = (cmp_a != cmp_b);
        ama_riscv_isa_pkg::BR_BLT:  cmp_true = ($signed(cmp_a) < $signed(cmp_b));
        ama_riscv_isa_pkg::BR_BGE:  cmp_true = ($signed(cmp_a) >= $signed(cmp_b));
        ama_riscv_isa_pkg::BR_BLTU: cmp_true = (cmp_a < cmp_b);
        ama_riscv_isa_pkg::BR_BGEU: cmp_true = (cmp_a >= cmp_b);
        default:                    cmp_true = (cmp_a == cmp_b);
    endcase
end

assign alu_result = exe.valid ? alu_out : '0;

// Branch target is pc + imm from the ALU
assign branch_taken  = exe.valid && exe.ctrl.branch_inst && cmp_true;
assign branch_target = (exe.valid && exe.ctrl.branch_inst) ? alu_out : '0;

// SW address is rs1 + imm
assign dmem_wr.we   = exe.valid && exe.ctrl.store_inst;
assign dmem_wr.addr = dmem_wr.we ? alu_out : '0;
assign dmem_wr.data = dmem_wr.we ? cmp_b : '0;

endmodule

/* design/ama_riscv_core.sv */
`timescale 1ns/1ps

module ama_riscv_core #(
    parameter ama_riscv_isa_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic                         clk,
    input  logic                         rst_n,
    output ama_riscv_isa_pkg::word_t     imem_addr,
    input  ama_riscv_isa_pkg::inst_t     imem_rdata,
    output ama_riscv_pipe_pkg::wb_t      wb,
    output ama_riscv_pipe_pkg::dmem_wr_t dmem_wr,
    output logic                         branch_taken,
    output ama_riscv_isa_pkg::word_t     branch_target
);

ama_riscv_isa_pkg::word_t pc;
ama_riscv_pipe_pkg::ctrl_t ctrl_dec;
ama_riscv_isa_pkg::word_t imm_dec;
ama_riscv_isa_pkg::word_t rf_rs1_data;
ama_riscv_isa_pkg::word_t rf_rs2_data;
ama_riscv_pipe_pkg::rd_we_t rd_we;
ama_riscv_pipe_pkg::fwd_sel_t fwd_sel_dec;
ama_riscv_pipe_pkg::exe_stage_t exe_stage_d;
ama_riscv_pipe_pkg::exe_stage_t exe_stage;
ama_riscv_pipe_pkg::mem_stage_t mem_stage_d;
ama_riscv_pipe_pkg::mem_stage_t mem_stage;
ama_riscv_isa_pkg::word_t alu_result_exe;

// Fetch
always_ff @(posedge clk) begin
    if (!rst_n) begin
        pc <= RESET_PC;
    end else if (branch_taken) begin
        pc <= branch_target;
    end else begin
        pc <= pc + 32'd4;
    end
end

assign imem_addr = pc;

ama_riscv_decoder u_decoder (
    .inst (imem_rdata),
    .ctrl (ctrl_dec),
    .imm  (imm_dec)
);

ama_riscv_reg_file u_reg_file (
    .clk      (clk),
    .rs1      (ctrl_dec.rs1),
    .rs2      (ctrl_dec.rs2),
    .rs1_data (rf_rs1_data),
    .rs2_data (rf_rs2_data),
    .we       (wb.we),
    .rd       (wb.rd),
    .rd_data  (wb.data)
);

assign rd_we.exe = exe_stage.valid && exe_stage.ctrl.rd_we;
assign rd_we.mem = mem_stage.valid && mem_stage.rd_we;

ama_riscv_operand_forwarding u_operand_forwarding (
    .rd_we           (rd_we),
    .store_inst_dec  (ctrl_dec.store_inst),
    .branch_inst_dec (ctrl_dec.branch_inst),
    .rs1_dec         (ctrl_dec.rs1),
    .rs2_dec         (ctrl_dec.rs2),
    .rd_exe          (exe_stage.ctrl.rd),
    .rd_mem          (mem_stage.rd),
    .alu_a_sel_dec   (ctrl_dec.alu_a_sel),
    .alu_b_sel_dec   (ctrl_dec.alu_b_sel),
    .fwd_sel         (fwd_sel_dec)
);

// DEC/EXE, a taken branch squashes the slot behind it
always_comb begin
    exe_stage_d.valid    = !branch_taken;
    exe_stage_d.ctrl     = ctrl_dec;
    exe_stage_d.pc       = pc;
    exe_stage_d.imm      = imm_dec;
    exe_stage_d.rs1_data = fwd_sel_dec.rf_a_sel ? wb.data : rf_rs1_data;
    exe_stage_d.rs2_data = fwd_sel_dec.rf_b_sel ? wb.data : rf_rs2_data;
    exe_stage_d.fwd_sel  = fwd_sel_dec;
end

ama_riscv_execute u_execute (
    .exe           (exe_stage),
    .alu_fwd_data  (mem_stage.alu_result),
    .alu_result    (alu_result_exe),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .dmem_wr       (dmem_wr)
);

// EXE/MEM
always_comb begin
    mem_stage_d.valid      = exe_stage.valid;
    mem_stage_d.rd_we      = exe_stage.ctrl.rd_we;
    mem_stage_d.rd         = exe_stage.ctrl.rd;
    mem_stage_d.alu_result = alu_result_exe;
end

// Stage registers
always_ff @(posedge clk) begin
    if (!rst_n) begin
        exe_stage.valid <= 1'b0;
        mem_stage.valid <= 1'b0;
    end else begin
        exe_stage <= exe_stage_d;
        mem_stage <= mem_stage_d;
    end
end

// Write-back
assign wb.we   = rd_we.mem;
assign wb.rd   = mem_stage.rd;
assign wb.data = mem_stage.alu_result;

endmodule

/* bench/ama_riscv_core_properties.sv */
`timescale 1ns/1ps

module ama_riscv_core_properties (
    input logic                         clk,
    input logic                         rst_n,
    input ama_riscv_pipe_pkg::wb_t      wb,
    input ama_riscv_pipe_pkg::dmem_wr_t dmem_wr,
    input logic                         branch_taken
);

// Quiet ports in reset and the first cycle after it
assert property (@(posedge clk) !rst_n |=> !wb.we && !dmem_wr.we)
    else $error("write port active around reset");

assert property (@(posedge clk) disable iff (!rst_n) wb.we |-> wb.rd != 5'd0)
    else $error("write-back to x0");

// Squashed slot makes no store in EXE and no write in MEM/WB
assert property (@(posedge clk) disable iff (!rst_n)
    branch_taken |=> (!dmem_wr.we && !wb.we && !branch_taken) ##1 !wb.we)
    else $error("squashed slot after taken branch was active");

endmodule

bind ama_riscv_core ama_riscv_core_properties u_ama_riscv_core_properties (
    .clk          (clk),
    .rst_n        (rst_n),
    .wb           (wb),
    .dmem_wr      (dmem_wr),
    .branch_taken (branch_taken)
);

/* bench/ama_riscv_core_tb.sv */
`timescale 1ns/1ps
`include "ama_riscv_defines.svh"

module ama_riscv_core_tb;

localparam int CLK_PERIOD = 4;

logic clk;
logic rst_n;
ama_riscv_isa_pkg::word_t     imem_addr;
ama_riscv_isa_pkg::inst_t     imem_rdata;
ama_riscv_pipe_pkg::wb_t      wb;
ama_riscv_pipe_pkg::dmem_wr_t dmem_wr;
logic                         branch_taken;
ama_riscv_isa_pkg::word_t     branch_target;

ama_riscv_isa_pkg::inst_t imem [0:255];
ama_riscv_isa_pkg::inst_t prog [$];
int prog_len;
int budget;
int cycles;

// Expected events from the reference model
ama_riscv_pipe_pkg::wb_t      wb_q [$];
ama_riscv_pipe_pkg::dmem_wr_t store_q [$];
ama_riscv_isa_pkg::word_t     branch_q [$];

ama_riscv_core #(
    .RESET_PC (32'h0000_0000)
) u_ama_riscv_core (
    .clk           (clk),
    .rst_n         (rst_n),
    .imem_addr     (imem_addr),
    .imem_rdata    (imem_rdata),
    .wb            (wb),
    .dmem_wr       (dmem_wr),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
);

// Same-cycle instruction memory, NOPs outside the program
assign imem_rdata = (imem_addr < 32'(prog_len * 4)) ? imem[imem_addr[9:2]] : `NOP_INST;

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
end

task automatic check_equal(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    if (actual !== expected) begin
        $display("[ERROR] %0t %s actual %h expected %h", $time, name, actual, expected);
        $display("STATUS: FAIL");
        $fatal(1);
    end
endtask

function automatic logic [31:0] rtype(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, ama_riscv_isa_pkg::OPC_OP};
endfunction

function automatic logic [31:0] itype(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                      logic [4:0] rd);
    return {imm, rs1, f3, rd, ama_riscv_isa_pkg::OPC_OP_IMM};
endfunction

function automatic logic [31:0] stype(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, ama_riscv_isa_pkg::F3_SW, imm[4:0],
            ama_riscv_isa_pkg::OPC_STORE};
endfunction

function automatic logic [31:0] btype(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11],
            ama_riscv_isa_pkg::OPC_BRANCH};
endfunction

function automatic logic [31:0] utype(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
    return {imm, rd, opc};
endfunction

// RV32I arithmetic from the ISA definition
function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                        logic [31:0] b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return {31'd0, $signed(a) < $signed(b)};
        3'd3: return {31'd0, a < b};
        3'd4: return a ^ b;
        3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_ref(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
        3'd0: return a == b;
        3'd1: return a != b;
        3'd4: return $signed(a) < $signed(b);
        3'd5: return $signed(a) >= $signed(b);
        3'd6: return a < b;
        default: return a >= b;
    endcase
endfunction

// In-order execution of the loaded program, no pipeline timing
task automatic run_model();
    logic [31:0] x [0:31];
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        wr;
    int          steps;
    for (int i = 0; i < 32; i++) x[i] = '0;
    pc = '0;
    steps = 0;
    while (pc < 32'(prog_len * 4) && steps < 1000) begin
        inst = imem[pc[9:2]];
        a = x[inst[19:15]];
        b = x[inst[24:20]];
        wr = 1'b1;
        res = '0;
        case (inst[6:0])
            ama_riscv_isa_pkg::OPC_OP:
                res = alu_ref(inst[14:12], inst[30], a, b);
            ama_riscv_isa_pkg::OPC_OP_IMM:
                res = alu_ref(inst[14:12], inst[30] && inst[14:12] == 3'd5, a,
                              {{20{inst[31]}}, inst[31:20]});
            ama_riscv_isa_pkg::OPC_LUI:
                res = {inst[31:12], 12'd0};
            ama_riscv_isa_pkg::OPC_AUIPC:
                res = pc + {inst[31:12], 12'd0};
            ama_riscv_isa_pkg::OPC_STORE: begin
                wr = 1'b0;
                store_q.push_back({1'b1, a + {{20{inst[31]}}, inst[31:25], inst[11:7]}, b});
            end
            default:
                wr = 1'b0;
        endcase
        if (wr && inst[11:7] != 5'd0) begin
            x[inst[11:7]] = res;
            wb_q.push_back({1'b1, inst[11:7], res});
        end
        if (inst[6:0] == ama_riscv_isa_pkg::OPC_BRANCH && branch_ref(inst[14:12], a, b)) begin
            pc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            branch_q.push_back(pc);
        end else begin
            pc = pc + 32'd4;
        end
        steps++;
    end
endtask

task automatic emit(input logic [31:0] word);
    prog.push_back(word);
endtask

// Loads x1..x7 with known values
task automatic init_regs();
    for (int i = 1; i < 8; i++) begin
        emit(itype(12'($urandom), 5'd0, 3'd0, 5'(i)));
    end
endtask

// Reset, load, model, then wait for the last expected event
task automatic run_program();
    rst_n <= 1'b0;
    @(posedge clk);
    for (int i = 0; i < 256; i++) imem[i] = (i < prog.size()) ? prog[i] : `NOP_INST;
    prog_len = prog.size();
    budget += 40 * prog_len;
    prog.delete();
    run_model();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    while (wb_q.size() != 0 || store_q.size() != 0 || branch_q.size() != 0) @(posedge clk);
    // Stray events in the tail would trip the monitors
    repeat (prog_len + 4) @(posedge clk);
endtask

task automatic independent_ops();
    init_regs();
    for (int f3 = 0; f3 < 8; f3++) begin
        emit(rtype(ama_riscv_isa_pkg::F7_BASE, 5'd2, 5'd1, 3'(f3), 5'd3));
        emit(`NOP_INST);
        emit(`NOP_INST);
        emit(itype(f3 == 1 || f3 == 5 ? 12'd7 : 12'hF85, 5'd4, 3'(f3), 5'd5));
        emit(`NOP_INST);
        emit(`NOP_INST);
    end
    emit(rtype(ama_riscv_isa_pkg::F7_ALT, 5'd2, 5'd1, 3'd0, 5'd6));
    emit(rtype(ama_riscv_isa_pkg::F7_ALT, 5'd7, 5'd4, 3'd5, 5'd6));
    emit(itype(12'h405, 5'd4, 3'd5, 5'd7));
    emit(`NOP_INST);
    emit(utype(20'hABCDE, 5'd1, ama_riscv_isa_pkg::OPC_LUI));
    emit(`NOP_INST);
    emit(utype(20'h00012, 5'd2, ama_riscv_isa_pkg::OPC_AUIPC));
    run_program();
endtask

task automatic exe_forwarding();
    init_regs();
    emit(rtype(ama_riscv_isa_pkg::F7_BASE, 5'd3, 5'd2, 3'd0, 5'd1));
    emit(rtype(ama_riscv_isa_pkg::F7_BASE, 5'd5, 5'd1, 3'd0, 5'd4));
    emit(rtype(ama_riscv_isa_pkg::F7_ALT, 5'd4, 5'd6, 3'd0, 5'd5));
    emit(rtype(ama_riscv_isa_pkg::F7_BASE, 5'd5, 5'd5, 3'd4, 5'd6));
    emit(rtype(ama_riscv_isa_pkg::F7_BASE, 5'd6, 5'd6, 3'd0, 5'd6));
    emit(itype(12'd5, 5'd6, 3'd0, 5'd7));
    emit(itype(12'd3, 5'd7, 3'd1, 5'd7));
    emit(rtype(ama_riscv_isa_pkg::F7_BASE, 5'd7, 5'd2, 3'd3, 5'd1));
    run_program();
endtask

task automatic wb_bypass();
    init_regs();
    emit(rtype(ama_riscv_isa_pkg::F7_BASE, 5'd1, 5'd1, 3'd0, 5'd2));
    emit(itype(12'd1, 5'd0, 3'd0, 5'd3));
    emit(rtype(ama_riscv_isa_pkg::F7_BASE, 5'd3, 5'd2, 3'd6, 5'd4));
    emit(`NOP_INST);
    emit(rtype(ama_riscv_isa_pkg::F7_BASE, 5'd4, 5'd4, 3'd0, 5'd5));
    // Writes to x0 are dropped, reads stay 0
    emit(itype(12'd77, 5'd1, 3'd0, 5'd0));
    emit(rtype(ama_riscv_isa_pkg::F7_BASE, 5'd1, 5'd0, 3'd0, 5'd5));
    emit(rtype(ama_riscv_isa_pkg::F7_BASE, 5'd2, 5'd1, 3'd0, 5'd0));
    emit(`NOP_INST);
    emit(rtype(ama_riscv_isa_pkg::F7_BASE, 5'd0, 5'd0, 3'd0, 5'd6));
    run_program();
endtask

task automatic branch_kinds();
    logic [2:0]  kinds [6];
    logic [11:0] rhs [3];
    kinds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    // Equal, both negative, and mixed sign against -3
    rhs = '{12'hFFD, 12'hFFE, 12'd5};
    init_regs();
    foreach (kinds[k]) begin
        foreach (rhs[v]) begin
            emit(itype(12'hFFD, 5'd0, 3'd0, 5'd1));
            emit(itype(rhs[v], 5'd0, 3'd0, 5'd2));
            emit(btype(13'd8, 5'd2, 5'd1, kinds[k]));
            emit(itype(12'd1, 5'd3, 3'd0, 5'd3));
            emit(itype(12'd1, 5'd4, 3'd0, 5'd4));
        end
    end
    run_program();
endtask

task automatic forwarded_stores();
    init_regs();
    emit(itype(12'h100, 5'd0, 3'd0, 5'd1));
    emit(itype(12'd55, 5'd0, 3'd0, 5'd2));
    emit(stype(12'd8, 5'd2, 5'd1));
    emit(stype(12'hFFC, 5'd1, 5'd2));
    emit(rtype(ama_riscv_isa_pkg::F7_BASE, 5'd2, 5'd1, 3'd0, 5'd3));
    emit(stype(12'd0, 5'd3, 5'd3));
    emit(stype(12'd4, 5'd0, 5'd0));
    run_program();
endtask

task automatic random_program();
    logic [2:0] f3;
    logic       alt;
    init_regs();
    for (int n = 0; n < 200; n++) begin
        f3 = 3'($urandom);
        alt = 1'($urandom);
        case ($urandom % 6)
            0: emit(rtype((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                          5'($urandom % 8), 5'($urandom % 8), f3, 5'($urandom % 8)));
            1: emit(itype(f3 == 3'd1 ? {7'h00, 5'($urandom)} :
                          f3 == 3'd5 ? {alt ? 7'h20 : 7'h00, 5'($urandom)} : 12'($urandom),
                          5'($urandom % 8), f3, 5'($urandom % 8)));
            2: emit(utype(20'($urandom), 5'($urandom % 8), ama_riscv_isa_pkg::OPC_LUI));
            3: emit(utype(20'($urandom), 5'($urandom % 8), ama_riscv_isa_pkg::OPC_AUIPC));
            4: emit(btype(13'(4 * (1 + $urandom % 4)), 5'($urandom % 8), 5'($urandom % 8),
                          (f3 == 3'd2 || f3 == 3'd3) ? 3'd0 : f3));
            default: emit(stype(12'($urandom), 5'($urandom % 8), 5'($urandom % 8)));
        endcase
    end
    run_program();
endtask

// Monitors sample at the falling edge
always @(negedge clk) begin
    if (rst_n && wb.we === 1'b1) begin
        if (wb_q.size() == 0) begin
            $display("Unexpected register write to x%0d at %0t", wb.rd, $time);
            $display("STATUS: FAIL");
            $fatal(1);
        end else begin
            check_equal("wb.rd", 32'(wb.rd), 32'(wb_q[0].rd));
            check_equal("wb.data", wb.data, wb_q[0].data);
            void'(wb_q.pop_front());
        end
    end
    if (rst_n && dmem_wr.we === 1'b1) begin
        if (store_q.size() == 0) begin
            $display("Unexpected store to %h at %0t", dmem_wr.addr, $time);
            $display("STATUS: FAIL");
            $fatal(1);
        end else begin
            check_equal("dmem_wr.addr", dmem_wr.addr, store_q[0].addr);
            check_equal("dmem_wr.data", dmem_wr.data, store_q[0].data);
            void'(store_q.pop_front());
        end
    end
    if (rst_n && branch_taken === 1'b1) begin
        if (branch_q.size() == 0) begin
            $display("Unexpected taken branch to %h at %0t", branch_target, $time);
            $display("STATUS: FAIL");
            $fatal(1);
        end else begin
            check_equal("branch_target", branch_target, branch_q[0]);
            void'(branch_q.pop_front());
        end
    end
end

// Watchdog, 40 cycles per loaded program word
initial begin
    cycles = 0;
    forever begin
        @(posedge clk);
        cycles++;
        if (cycles > budget) begin
            $display("Timeout: the core did not produce the expected events in time");
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end
end

initial begin
    void'($urandom(87111));
    rst_n = 1'b0;
    prog_len = 0;
    budget = 20;
    independent_ops();
    exe_forwarding();
    wb_bypass();
    branch_kinds();
    forwarded_stores();
    random_program();
    $display("STATUS: PASS");
    $finish;
end

endmodule

/* project.f */
+incdir+design
design/ama_riscv_isa_pkg.sv
design/ama_riscv_pipe_pkg.sv
design/ama_riscv_decoder.sv
design/ama_riscv_reg_file.sv
design/ama_riscv_operand_forwarding.sv
design/ama_riscv_execute.sv
design/ama_riscv_core.sv
bench/ama_riscv_core_properties.sv
bench/ama_riscv_core_tb.sv

/* Makefile */
TOP = ama_riscv_core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
